/* exec_units.f */
design/rv32_isa_pkg.sv
design/exec_pkg.sv
design/alu.sv
design/branch_resolve.sv
design/alu_unit.sv
design/mult_stage.sv
design/mult_unit.sv
design/exec_units.sv
dv/clock_gen.sv
dv/exec_tb.sv

/* dv/exec_tb.sv */
`timescale 1ns/1ps

module exec_tb
    import rv32_isa_pkg::*;
    import exec_pkg::*;
();

    localparam int          MULT_STAGES  = 4;
    localparam int          ROW_CYCLES   = 200;  // watchdog budget per table row
    localparam logic [31:0] SEED         = 32'h5a8f5ad5;
    localparam logic [1:0]  READY_ALWAYS = 2'd0;
    localparam logic [1:0]  READY_RANDOM = 2'd1;
    localparam logic [1:0]  READY_NEVER  = 2'd2;

    typedef struct {
        issue_pkt_t pkt;
        xlen_t      exp_result;
        logic       exp_redirect;
        logic       exp_taken;   // bp_update.cond_taken
        xlen_t      exp_target;  // bp_update.target
    } row_t;

    logic         clock;
    logic         reset;
    logic         clear;
    logic         issue_valid;
    logic         issue_ready;
    issue_pkt_t   issue;
    logic         alu_valid;
    logic         alu_ready;
    alu_result_t  alu_out;
    bp_update_t   bp_update;
    logic         mult_valid;
    logic         mult_ready;
    mult_result_t mult_out;

    row_t        rows[$];
    row_t        cur_row;       // row currently on the issue port
    row_t        alu_exp[$];
    row_t        mult_exp[$];
    int          mult_acc_cycle[$];
    int          mult_acc_stalls[$];
    int          cycle        = 0;
    int          stall_count  = 0;
    int          mismatches   = 0;
    int          other_errors = 0;
    int          first_mult   = 0;
    logic [1:0]  ready_mode;
    logic        expect_idle;
    logic [31:0] rand_state   = SEED;

    clock_gen u_clock_gen (.clock(clock), .reset(reset));

    exec_units #(.MULT_STAGES(MULT_STAGES)) u_exec_units (
        .clock       (clock),
        .reset       (reset),
        .clear       (clear),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue       (issue),
        .alu_valid   (alu_valid),
        .alu_ready   (alu_ready),
        .alu_out     (alu_out),
        .bp_update   (bp_update),
        .mult_valid  (mult_valid),
        .mult_ready  (mult_ready),
        .mult_out    (mult_out)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic issue_pkt_t make_pkt(input inst_t inst, input xlen_t pc, input xlen_t npc,
                                            input xlen_t rs1, input xlen_t rs2);
        issue_pkt_t p;
        p           = '0;
        p.inst      = inst;
        p.pc        = pc;
        p.npc       = npc;
        p.rs1_value = rs1;
        p.rs2_value = rs2;
        p.tag       = tag_t'(rows.size());
        return p;
    endfunction

    task automatic alu_row(input alu_func_e func, input opa_sel_e opa, input opb_sel_e opb,
                           input inst_t inst, input xlen_t pc, input xlen_t rs1, input xlen_t rs2,
                           input xlen_t expected);
        row_t r;
        r.pkt          = make_pkt(inst, pc, pc + 32'd4, rs1, rs2);
        r.pkt.opa_sel  = opa;
        r.pkt.opb_sel  = opb;
        r.pkt.alu_func = func;
        r.pkt.unit     = unit_alu;
        r.exp_result   = expected;
        r.exp_redirect = 1'b0;
        r.exp_taken    = 1'b0;
        r.exp_target   = expected; // target is the plain alu output
        rows.push_back(r);
    endtask

    task automatic branch_row(input inst_t inst, input xlen_t pc, input xlen_t npc,
                              input xlen_t rs1, input xlen_t rs2, input logic uncond,
                              input xlen_t expected, input logic redirect, input logic taken,
                              input xlen_t target);
        row_t r;
        r.pkt               = make_pkt(inst, pc, npc, rs1, rs2);
        r.pkt.opa_sel       = opa_pc;
        r.pkt.opb_sel       = uncond ? opb_j_imm : opb_b_imm;
        r.pkt.alu_func      = alu_add;
        r.pkt.unit          = unit_alu;
        r.pkt.cond_branch   = !uncond;
        r.pkt.uncond_branch = uncond;
        r.exp_result        = expected;
        r.exp_redirect      = redirect;
        r.exp_taken         = taken;
        r.exp_target        = target;
        rows.push_back(r);
    endtask

    task automatic mult_row(input alu_func_e func, input xlen_t rs1, input xlen_t rs2,
                            input logic halt, input xlen_t expected);
        row_t  r;
        xlen_t pc;
        pc             = 32'h3000 + 4 * rows.size();
        r.pkt          = make_pkt(nop_inst, pc, pc + 32'd4, rs1, rs2);
        r.pkt.alu_func = func;
        r.pkt.unit     = unit_mult;
        r.pkt.halt     = halt;
        r.exp_result   = expected;
        r.exp_redirect = 1'b0;
        r.exp_taken    = 1'b0;
        r.exp_target   = '0;
        rows.push_back(r);
    endtask

    task automatic build_table();
        alu_row(alu_add, opa_rs1, opb_rs2, nop_inst, 32'h2000, 32'd5, 32'd7, 32'hc);
        alu_row(alu_sub, opa_rs1, opb_rs2, nop_inst, 32'h2004, 32'd3, 32'd5, 32'hfffffffe);
        alu_row(alu_and, opa_rs1, opb_i_imm, {12'h0f0, 20'h00013}, 32'h2008, 32'h123456ff,
                32'd0, 32'hf0);
        alu_row(alu_or, opa_rs1, opb_i_imm, {12'hf00, 20'h00013}, 32'h200c, 32'h1234,
                32'd0, 32'hffffff34);                       // negative immediate
        alu_row(alu_xor, opa_pc, opb_rs2, nop_inst, 32'h2010, 32'd0, 32'hffff, 32'hdfef);
        alu_row(alu_slt, opa_rs1, opb_rs2, nop_inst, 32'h2014, 32'hffffffff, 32'd1, 32'h1);
        alu_row(alu_sltu, opa_rs1, opb_rs2, nop_inst, 32'h2018, 32'hffffffff, 32'd1, 32'h0);
        alu_row(alu_sll, opa_rs1, opb_i_imm, {12'h024, 20'h01013}, 32'h201c, 32'h80000001,
                32'd0, 32'h10);                             // only 5 bits of shift used
        alu_row(alu_srl, opa_npc, opb_rs2, nop_inst, 32'h2020, 32'd0, 32'd2, 32'h809);
        alu_row(alu_sra, opa_rs1, opb_rs2, nop_inst, 32'h2024, 32'h80000000, 32'd4,
                32'hf8000000);
        alu_row(alu_add, opa_pc, opb_u_imm, {20'h12345, 12'h017}, 32'h2000, 32'd0, 32'd0,
                32'h12347000);                              // auipc
        alu_row(alu_add, opa_zero, opb_u_imm, {20'habcde, 12'h037}, 32'h2030, 32'd0, 32'd0,
                32'habcde000);                              // lui
        rows[rows.size() - 1].pkt.halt = 1'b1;              // halt through the alu path
        // branches, offset +16 except the bgeu row at -8
        branch_row(32'h00000863, 32'h4000, 32'h4004, 32'd7, 32'd7, 1'b0,
                   32'h4010, 1'b1, 1'b1, 32'h4010);
        branch_row(32'h00001863, 32'h4100, 32'h4110, 32'd7, 32'd7, 1'b0,
                   32'h4104, 1'b1, 1'b0, 32'h4110);
        branch_row(32'h00004863, 32'h4200, 32'h4210, 32'hfffffffe, 32'd1, 1'b0,
                   32'h4210, 1'b0, 1'b1, 32'h4210);
        branch_row(32'h00005863, 32'h4300, 32'h4304, 32'hfffffffe, 32'd1, 1'b0,
                   32'h4310, 1'b0, 1'b0, 32'h4310);
        branch_row(32'h00006863, 32'h4400, 32'h4420, 32'd1, 32'hfffffffe, 1'b0,
                   32'h4410, 1'b1, 1'b1, 32'h4410);        // taken, wrong target
        branch_row(32'hfe007ce3, 32'h4500, 32'h4504, 32'hfffffffe, 32'd1, 1'b0,
                   32'h44f8, 1'b1, 1'b1, 32'h44f8);
        branch_row(32'h1000006f, 32'h4700, 32'h4704, 32'd0, 32'd0, 1'b1,
                   32'h4800, 1'b1, 1'b0, 32'h4800);        // jal +0x100
        branch_row(32'h1000006f, 32'h4800, 32'h4900, 32'd0, 32'd0, 1'b1,
                   32'h4900, 1'b0, 1'b0, 32'h4900);
        first_mult = rows.size();
        mult_row(alu_mul, 32'hfffffffd, 32'd7, 1'b0, 32'hffffffeb);
        mult_row(alu_mulh, 32'hfffffffd, 32'd7, 1'b0, 32'hffffffff);
        mult_row(alu_mulhsu, 32'hfffffffd, 32'h80000000, 1'b0, 32'hfffffffe);
        mult_row(alu_mulhu, 32'hffffffff, 32'hffffffff, 1'b0, 32'hfffffffe);
        mult_row(alu_mulh, 32'h80000000, 32'h80000000, 1'b0, 32'h40000000);
        mult_row(alu_mulhsu, 32'd2, 32'hffffffff, 1'b0, 32'h1);
        mult_row(alu_mul, 32'h00010001, 32'h00010001, 1'b1, 32'h00020001);
    endtask

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
        assert (got === expected) else begin
            $display("MISMATCH %s: got %h, expected %h", name, got, expected);
            mismatches++;
        end
    endtask

    task automatic score_alu_result();
        row_t r;
        assert (alu_exp.size() != 0) else begin
            $display("ALU result with tag %h arrived but none was pending", alu_out.tag);
            other_errors++;
        end
        if (alu_exp.size() != 0) begin
            r = alu_exp.pop_front();
            compare_field("alu_out.result", alu_out.result, r.exp_result);
            compare_field("alu_out.redirect", alu_out.redirect, r.exp_redirect);
            compare_field("alu_out.npc", alu_out.npc, r.pkt.pc + 32'd4);
            compare_field("alu_out.tag", alu_out.tag, r.pkt.tag);
            compare_field("alu_out.halt", alu_out.halt, r.pkt.halt);
            compare_field("bp_update.pc", bp_update.pc, r.pkt.pc);
            compare_field("bp_update.is_branch", bp_update.is_branch,
                          r.pkt.cond_branch | r.pkt.uncond_branch);
            compare_field("bp_update.is_cond", bp_update.is_cond, r.pkt.cond_branch);
            compare_field("bp_update.cond_taken", bp_update.cond_taken, r.exp_taken);
            compare_field("bp_update.target", bp_update.target, r.exp_target);
        end
    endtask

    task automatic score_mult_result();
        row_t r;
        int   latency;
        int   stalls;
        assert (mult_exp.size() != 0) else begin
            $display("multiplier result with tag %h arrived but none was pending", mult_out.tag);
            other_errors++;
        end
        if (mult_exp.size() != 0) begin
            r       = mult_exp.pop_front();
            latency = cycle - mult_acc_cycle.pop_front();
            stalls  = stall_count - mult_acc_stalls.pop_front();
            compare_field("mult_out.result", mult_out.result, r.exp_result);
            compare_field("mult_out.npc", mult_out.npc, r.pkt.npc);
            compare_field("mult_out.tag", mult_out.tag, r.pkt.tag);
            compare_field("mult_out.halt", mult_out.halt, r.pkt.halt);
            compare_field("mult_out latency", latency, MULT_STAGES + stalls);
        end
    endtask

    // result port back-pressure
    always @(posedge clock) begin
        rand_state = lcg_next(rand_state);
        case (ready_mode)
            READY_RANDOM: begin
                alu_ready  <= rand_state[30] | rand_state[27];
                mult_ready <= rand_state[29] | rand_state[25];
            end
            READY_NEVER: begin
                alu_ready  <= 1'b0;
                mult_ready <= 1'b0;
            end
            default: begin
                alu_ready  <= 1'b1;
                mult_ready <= 1'b1;
            end
        endcase
    end

    // monitor, samples the values present at the edge
    always @(posedge clock) begin
        if (!reset) begin
            if (issue_valid && issue_ready) begin
                if (cur_row.pkt.unit == unit_alu) begin
                    alu_exp.push_back(cur_row);
                end else begin
                    mult_exp.push_back(cur_row);
                    mult_acc_cycle.push_back(cycle);
                    mult_acc_stalls.push_back(stall_count);
                end
            end
            if (alu_valid && alu_ready) begin
                score_alu_result();
            end
            if (mult_valid && mult_ready) begin
                score_mult_result();
            end
            if (mult_valid && !mult_ready) begin
                stall_count++;  // whole multiplier pipe held
            end
            assert (!(expect_idle && (alu_valid || mult_valid))) else begin
                $display("a result port went valid after clear with nothing issued");
                other_errors++;
            end
            if (clear) begin
                alu_exp.delete();
                mult_exp.delete();
                mult_acc_cycle.delete();
                mult_acc_stalls.delete();
            end
        end
        cycle++;
    end

    task automatic issue_row(input row_t r);
        issue_valid <= 1'b1;
        issue       <= r.pkt;
        cur_row     <= r;
        @(posedge clock);
        while (!issue_ready) begin
            @(posedge clock);
        end
    endtask

    task automatic drain_results();
        issue_valid <= 1'b0;
        @(posedge clock);
        while (alu_exp.size() != 0 || mult_exp.size() != 0) begin
            @(posedge clock);
        end
    endtask

    initial begin
        clear       = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        alu_ready   = 1'b0;
        mult_ready  = 1'b0;
        ready_mode  = READY_ALWAYS;
        expect_idle = 1'b0;
        build_table();
        cur_row     = rows[0];
        @(posedge clock);
        while (reset) begin
            @(posedge clock);
        end
        // first pass without back-pressure, second with it
        for (int pass = 0; pass < 2; pass++) begin
            ready_mode <= (pass == 0) ? READY_ALWAYS : READY_RANDOM;
            foreach (rows[i]) begin
                issue_row(rows[i]);
            end
            drain_results();
        end
        // fill both units with results held, then clear them
        ready_mode <= READY_NEVER;
        repeat (2) @(posedge clock);
        issue_row(rows[0]);
        issue_row(rows[first_mult]);
        issue_row(rows[first_mult + 1]);
        issue_valid <= 1'b0;
        clear       <= 1'b1;
        @(posedge clock);
        clear       <= 1'b0;
        expect_idle <= 1'b1;
        ready_mode  <= READY_RANDOM;
        repeat (10) @(posedge clock);
        expect_idle <= 1'b0;
        issue_row(rows[first_mult + 2]);
        issue_row(rows[1]);
        drain_results();
        $display("errors: %0d value mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches + other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        int limit;
        #1;
        limit = ROW_CYCLES * (2 * rows.size() + 6);
        repeat (limit) @(posedge clock);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("errors: %0d value mismatches, %0d other failures", mismatches, other_errors);
        $display("Verification failed");
        $finish;
    end

endmodule

/* dv/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    // reset released on a rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

/* design/exec_units.sv */
`timescale 1ns/1ps

module exec_units
    import exec_pkg::*;
#(
    parameter int MULT_STAGES = 4
) (
    input  logic         clock,
    input  logic         reset,
    input  logic         clear,
    input  logic         issue_valid,
    output logic         issue_ready,
    input  issue_pkt_t   issue,
    output logic         alu_valid,
    input  logic         alu_ready,
    output alu_result_t  alu_out,
    output bp_update_t   bp_update,
    output logic         mult_valid,
    input  logic         mult_ready,
    output mult_result_t mult_out
);

    logic to_alu;
    logic alu_in_ready;
    logic mult_in_ready;

    assign to_alu      = issue.unit == unit_alu;
    assign issue_ready = to_alu ? alu_in_ready : mult_in_ready;

    alu_unit u_alu_unit (
        .clock     (clock),
        .reset     (reset),
        .clear     (clear),
        .in_valid  (issue_valid && to_alu),
        .in_ready  (alu_in_ready),
        .issue     (issue),
        .out_valid (alu_valid),
        .out_ready (alu_ready),
        .out       (alu_out),
        .bp_update (bp_update)
    );

    mult_unit #(.MULT_STAGES(MULT_STAGES)) u_mult_unit (
        .clock     (clock),
        .reset     (reset),
        .clear     (clear),
        .in_valid  (issue_valid && !to_alu),
        .in_ready  (mult_in_ready),
        .issue     (issue),
        .out_valid (mult_valid),
        .out_ready (mult_ready),
        .out       (mult_out)
    );

endmodule

/* design/mult_unit.sv */
`timescale 1ns/1ps

module mult_unit
    import exec_pkg::*;
#(
    parameter int MULT_STAGES = 4
) (
    input  logic         clock,
    input  logic         reset,
    input  logic         clear,
    input  logic         in_valid,
    output logic         in_ready,
    input  issue_pkt_t   issue,
    output logic         out_valid,
    input  logic         out_ready,
    output mult_result_t out
);

    logic                           advance;
    logic                           flush;
    logic                           high_half;
    dword_t                         mcand_in;
    dword_t                         mplier_in;
    mult_result_t                   meta_in;
    logic         [MULT_STAGES:0]   valids;
    dword_t       [MULT_STAGES:0]   sums;
    dword_t       [MULT_STAGES:0]   mpliers;
    dword_t       [MULT_STAGES:0]   mcands;
    mult_result_t [MULT_STAGES:0]   metas;

    always_comb begin
        high_half = 1'b1;
        case (issue.alu_func)
            alu_mul: begin
                mcand_in  = {{XLEN{issue.rs1_value[XLEN-1]}}, issue.rs1_value};
                mplier_in = {{XLEN{issue.rs2_value[XLEN-1]}}, issue.rs2_value};
                high_half = 1'b0;
            end
            alu_mulh: begin
                mcand_in  = {{XLEN{issue.rs1_value[XLEN-1]}}, issue.rs1_value};
                mplier_in = {{XLEN{issue.rs2_value[XLEN-1]}}, issue.rs2_value};
            end
            alu_mulhsu: begin
                mcand_in  = {{XLEN{issue.rs1_value[XLEN-1]}}, issue.rs1_value};
                mplier_in = {{XLEN{1'b0}}, issue.rs2_value};
            end
            alu_mulhu: begin
                mcand_in  = {{XLEN{1'b0}}, issue.rs1_value};
                mplier_in = {{XLEN{1'b0}}, issue.rs2_value};
            end
            default: begin
                mcand_in  = '0;
                mplier_in = '0;
                high_half = 1'b0;
            end
        endcase
    end

    assign meta_in = '{result: {{(XLEN-1){1'b0}}, high_half},
                       npc: issue.npc, tag: issue.tag, halt: issue.halt};

    assign advance  = !(out_valid && !out_ready); // whole pipe stalls together
    assign in_ready = advance;
    assign flush    = reset || clear;

    assign valids[0]  = in_valid;
    assign sums[0]    = '0;
    assign mpliers[0] = mplier_in;
    assign mcands[0]  = mcand_in;
    assign metas[0]   = meta_in;

    for (genvar i = 0; i < MULT_STAGES; i++) begin : g_stage
        mult_stage #(.MULT_STAGES(MULT_STAGES)) u_stage (
            .clock       (clock),
            .reset       (flush),
            .advance     (advance),
            .in_valid    (valids[i]),
            .prev_sum    (sums[i]),
            .mplier      (mpliers[i]),
            .mcand       (mcands[i]),
            .in_meta     (metas[i]),
            .out_valid   (valids[i+1]),
            .sum         (sums[i+1]),
            .next_mplier (mpliers[i+1]),
            .next_mcand  (mcands[i+1]),
            .out_meta    (metas[i+1])
        );
    end

    assign out_valid = valids[MULT_STAGES];

    always_comb begin
        out        = metas[MULT_STAGES];
        out.result = metas[MULT_STAGES].result[0] ? sums[MULT_STAGES][2*XLEN-1:XLEN]
                                                  : sums[MULT_STAGES][XLEN-1:0];
    end

endmodule

/* design/mult_stage.sv */
`timescale 1ns/1ps

module mult_stage
    import exec_pkg::*;
#(
    parameter int MULT_STAGES = 4
) (
    input  logic         clock,
    input  logic         reset,
    input  logic         advance,
    input  logic         in_valid,
    input  dword_t       prev_sum,
    input  dword_t       mplier,
    input  dword_t       mcand,
    input  mult_result_t in_meta,
    output logic         out_valid,
    output dword_t       sum,
    output dword_t       next_mplier,
    output dword_t       next_mcand,
    output mult_result_t out_meta
);

    localparam int SHIFT = 64 / MULT_STAGES; // multiplier bits per stage

    dword_t partial;

    assign partial = mplier[SHIFT-1:0] * mcand;

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= in_valid;
        end
    end

    // datapath and metadata
    always_ff @(posedge clock) begin
        if (advance) begin
            sum         <= prev_sum + partial;
            next_mplier <= mplier >> SHIFT;
            next_mcand  <= mcand << SHIFT;
            out_meta    <= in_meta;  // high-half flag rides in result
        end
    end

endmodule

/* design/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit
    import rv32_isa_pkg::*;
    import exec_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        clear,
    input  logic        in_valid,
    output logic        in_ready,
    input  issue_pkt_t  issue,
    output logic        out_valid,
    input  logic        out_ready,
    output alu_result_t out,
    output bp_update_t  bp_update
);

    xlen_t       opa;
    xlen_t       opb;
    xlen_t       alu_res;
    xlen_t       pc_plus4;
    logic        redirect;
    logic        actual_taken;
    logic        pred_taken;
    bp_update_t  bp_next;
    alu_result_t out_next;

    always_comb begin
        case (issue.opa_sel)
            opa_rs1:  opa = issue.rs1_value;
            opa_npc:  opa = issue.npc;
            opa_pc:   opa = issue.pc;
            default:  opa = '0;
        endcase
    end

    always_comb begin
        case (issue.opb_sel)
            opb_rs2:   opb = issue.rs2_value;
            opb_i_imm: opb = i_imm(issue.inst);
            opb_b_imm: opb = b_imm(issue.inst);
            opb_u_imm: opb = u_imm(issue.inst);
            opb_j_imm: opb = j_imm(issue.inst);
            default:   opb = '0;
        endcase
    end

    alu u_alu (.opa(opa), .opb(opb), .func(issue.alu_func), .result(alu_res));

    branch_resolve u_branch_resolve (
        .issue      (issue),
        .alu_result (alu_res),
        .redirect   (redirect),
        .bp_update  (bp_next)
    );

    assign pc_plus4     = issue.pc + 32'd4;
    assign pred_taken   = issue.npc != pc_plus4;
    assign actual_taken = issue.uncond_branch | bp_next.cond_taken;

    always_comb begin
        out_next.result   = alu_res;
        out_next.npc      = pc_plus4;
        out_next.tag      = issue.tag;
        out_next.halt     = issue.halt;
        out_next.redirect = redirect;
        // wrongly taken: fetch resumes at the fall-through
        if (redirect && pred_taken && !actual_taken) begin
            out_next.result = pc_plus4;
        end
    end

    assign in_ready = !out_valid || out_ready; // empty or draining

    always_ff @(posedge clock) begin
        if (reset || clear) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid && in_ready) begin
            out       <= out_next;
            bp_update <= bp_next;
        end
    end

endmodule

/* design/branch_resolve.sv */
`timescale 1ns/1ps

module branch_resolve
    import rv32_isa_pkg::*;
    import exec_pkg::*;
(
    input  issue_pkt_t issue,
    input  xlen_t      alu_result,  // computed target
    output logic       redirect,
    output bp_update_t bp_update
);

    logic signed [XLEN-1:0] srs1;
    logic signed [XLEN-1:0] srs2;
    logic                   cond_true;
    logic                   taken;
    logic                   pred_taken;

    assign srs1 = issue.rs1_value;
    assign srs2 = issue.rs2_value;

    always_comb begin
        case (get_funct3(issue.inst))
            br_beq:  cond_true = issue.rs1_value == issue.rs2_value;
            br_bne:  cond_true = issue.rs1_value != issue.rs2_value;
            br_blt:  cond_true = srs1 < srs2;
            br_bge:  cond_true = srs1 >= srs2;
            br_bltu: cond_true = issue.rs1_value < issue.rs2_value;
            br_bgeu: cond_true = issue.rs1_value >= issue.rs2_value;
            default: cond_true = 1'b0;
        endcase
    end

    assign taken      = issue.uncond_branch | (issue.cond_branch & cond_true);
    assign pred_taken = issue.npc != issue.pc + 32'd4;

    // predicted taken: wrong if not taken or target differs
    always_comb begin
        if (pred_taken) begin
            redirect = !taken || (issue.npc != alu_result);
        end else begin
            redirect = taken;
        end
    end

    always_comb begin
        bp_update.pc         = issue.pc;
        bp_update.is_branch  = issue.cond_branch | issue.uncond_branch;
        bp_update.is_cond    = issue.cond_branch;
        bp_update.cond_taken = issue.cond_branch & cond_true;
        bp_update.target     = alu_result;
    end

endmodule

/* design/alu.sv */
`timescale 1ns/1ps

module alu
    import exec_pkg::*;
(
    input  xlen_t     opa,
    input  xlen_t     opb,
    input  alu_func_e func,
    output xlen_t     result
);

    logic signed [XLEN-1:0] sopa;
    logic signed [XLEN-1:0] sopb;
    logic [4:0]             shamt;

    assign sopa  = opa;
    assign sopb  = opb;
    assign shamt = opb[4:0]; // rv32 shifts use 5 bits

    always_comb begin
        case (func)
            alu_add:  result = opa + opb;
            alu_sub:  result = opa - opb;
            alu_and:  result = opa & opb;
            alu_or:   result = opa | opb;
            alu_xor:  result = opa ^ opb;
            alu_slt:  result = {{(XLEN-1){1'b0}}, sopa < sopb};
            alu_sltu: result = {{(XLEN-1){1'b0}}, opa < opb};
            alu_sll:  result = opa << shamt;
            alu_srl:  result = opa >> shamt;
            alu_sra:  result = sopa >>> shamt;
            default:  result = '0; // multiplies go to the mult unit
        endcase
    end

endmodule

/* design/exec_pkg.sv */
package exec_pkg;

    import rv32_isa_pkg::*;

    localparam int XLEN     = 32;
    localparam int ROB_SIZE = 32;
    localparam int TAG_W    = $clog2(ROB_SIZE);

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [2*XLEN-1:0] dword_t;  // full product
    typedef logic [TAG_W-1:0]  tag_t;    // rob index

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra,
        alu_mul, alu_mulh, alu_mulhsu, alu_mulhu
    } alu_func_e;

    typedef enum logic [1:0] {opa_rs1, opa_npc, opa_pc, opa_zero} opa_sel_e;

    typedef enum logic [2:0] {opb_rs2, opb_i_imm, opb_b_imm, opb_u_imm, opb_j_imm} opb_sel_e;

    typedef enum logic {unit_alu, unit_mult} unit_e;

    typedef struct packed {
        inst_t     inst;
        xlen_t     pc;
        xlen_t     npc;        // predicted next pc
        xlen_t     rs1_value;
        xlen_t     rs2_value;
        opa_sel_e  opa_sel;
        opb_sel_e  opb_sel;
        alu_func_e alu_func;
        unit_e     unit;
        logic      cond_branch;
        logic      uncond_branch;
        logic      halt;
        tag_t      tag;
    } issue_pkt_t;

    typedef struct packed {
        xlen_t result;
        xlen_t npc;
        tag_t  tag;
        logic  halt;
        logic  redirect;
    } alu_result_t;

    typedef struct packed {
        xlen_t result;
        xlen_t npc;
        tag_t  tag;
        logic  halt;
    } mult_result_t;

    typedef struct packed {
        xlen_t pc;
        logic  is_branch;
        logic  is_cond;
        logic  cond_taken;
        xlen_t target;
    } bp_update_t;

endpackage

/* design/rv32_isa_pkg.sv */
package rv32_isa_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [2:0]  funct3_t;

    // r-type field view of the instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3_t    funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_fields_t;

    // conditional branch conditions
    localparam funct3_t br_beq  = 3'b000;
    localparam funct3_t br_bne  = 3'b001;
    localparam funct3_t br_blt  = 3'b100;
    localparam funct3_t br_bge  = 3'b101;
    localparam funct3_t br_bltu = 3'b110;
    localparam funct3_t br_bgeu = 3'b111;

    localparam inst_t nop_inst = 32'h0000_0013; // addi x0, x0, 0

    function automatic funct3_t get_funct3(inst_t inst);
        inst_fields_t f;
        f = inst_fields_t'(inst);
        return f.funct3;
    endfunction

    function automatic logic [31:0] i_imm(inst_t inst);
        return {{20{inst[31]}}, inst[31:20]};
    endfunction

    function automatic logic [31:0] b_imm(inst_t inst);
        return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] u_imm(inst_t inst);
        return {inst[31:12], 12'b0};
    endfunction

    function automatic logic [31:0] j_imm(inst_t inst);
        return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

endpackage
